//--- Bender.yml
package:
  name: arb_two_class

sources:
  - include_dirs:
      - logic
    files:
      - logic/arbRegPkg.sv
      - logic/arbGrantPkg.sv
      - logic/encPriorityFixed.sv
      - logic/encPriorityDynamic.sv
      - logic/grantCombiner.sv
      - logic/arbApbRegs.sv
      - logic/arbTop.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tbClock.sv
      - sim/arbChecker.sv
      - sim/tbArbTop.sv

//--- logic/arbApbRegs.sv
// APB slave with the enable bit, the urgent mask and the grant cycle counter
`timescale 1ns/1ps
`include "arbMacros.svh"

module arbApbRegs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                PSEL,
  input  logic                                PENABLE,
  input  logic                                PWRITE,
  input  logic [`ARB_APB_ADDR_W-1:0]          PADDR,
  input  logic [`ARB_APB_DATA_W-1:0]          PWDATA,
  output logic [`ARB_APB_DATA_W-1:0]          PRDATA,
  output logic                                PREADY,
  output logic                                PSLVERR,
  output logic                                enable,
  output logic [`ARB_NUM_REQ-1:0]             urgentMask,
  input  logic [arbRegPkg::GRANT_COUNT_W-1:0] grantCount
);

  logic accessPhase;
  logic addrHit;
  logic [`ARB_APB_DATA_W-1:0] rdData;
  arbRegPkg::regAddrE regAddr;

  // ----------------------------------------
  // Access decode
  // ----------------------------------------
  // Second cycle of every transfer
  assign accessPhase = PSEL & PENABLE;
  assign regAddr = arbRegPkg::regAddrE'(PADDR);

  // Read mux and address check
  always_comb begin
    addrHit = 1'b1;
    rdData = '0;
    case (regAddr)
      arbRegPkg::REG_CTRL: begin
        rdData[arbRegPkg::CTRL_ENABLE_BIT] = enable;
      end
      arbRegPkg::REG_URGENT: begin
        rdData[arbRegPkg::URGENT_MASK_W-1:0] = urgentMask;
      end
      arbRegPkg::REG_GRANT_COUNT: begin
        rdData[arbRegPkg::GRANT_COUNT_W-1:0] = grantCount;
      end
      default: begin
        addrHit = 1'b0;
      end
    endcase
  end

  // ----------------------------------------
  // Control registers
  // ----------------------------------------
  // Writes land on the edge that closes the access phase
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
      urgentMask <= '0;
    end else if (accessPhase && PWRITE) begin
      case (regAddr)
        arbRegPkg::REG_CTRL: begin
          enable <= PWDATA[arbRegPkg::CTRL_ENABLE_BIT];
        end
        arbRegPkg::REG_URGENT: begin
          urgentMask <= PWDATA[arbRegPkg::URGENT_MASK_W-1:0];
        end
        // Counter is read-only and unmapped writes are dropped
        default: begin
        end
      endcase
    end
  end

  // ----------------------------------------
  // Bus responses
  // ----------------------------------------
  // No wait states
  assign PREADY = 1'b1;
  // Error only for addresses outside the map
  assign PSLVERR = accessPhase & ~addrHit;
  // Read data driven during the access phase of a read
  assign PRDATA = (accessPhase && !PWRITE) ? rdData : '0;

endmodule

//--- logic/arbGrantPkg.sv
// Grant decision types shared by the combiner, the top level and the checker

package arbGrantPkg;

  // ----------------------------------------
  // Grant source
  // ----------------------------------------
  // Encoding width of the source tag
  localparam int GRANT_SRC_W = 2;

  // Which path produced the registered grants
  typedef enum logic [GRANT_SRC_W-1:0] {
    // No grant this cycle
    GRANT_NONE   = 2'd0,
    // Fixed-priority urgent path won
    GRANT_URGENT = 2'd1,
    // Rotating round-robin path won
    GRANT_ROUND  = 2'd2
  } grantSrcE;

endpackage

//--- logic/arbMacros.svh
// Sizing macros for the two-class request arbiter and its APB port
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// ----------------------------------------
// Arbiter sizing
// ----------------------------------------
// Requesters on the request vector
`define ARB_NUM_REQ 8
// Grants issued per cycle
`define ARB_NUM_GRANTS 2

// ----------------------------------------
// APB bus widths
// ----------------------------------------
// Byte address width
`define ARB_APB_ADDR_W 8
`define ARB_APB_DATA_W 32

`endif

//--- logic/arbRegPkg.sv
// Register map of the arbiter APB slave with addresses and field widths
`include "arbMacros.svh"

package arbRegPkg;

  // ----------------------------------------
  // Field widths and positions
  // ----------------------------------------
  // Counter of cycles that issued a grant
  localparam int GRANT_COUNT_W = 32;
  // Enable sits in bit 0 of the control word
  localparam int CTRL_ENABLE_BIT = 0;
  // One urgent bit per requester
  localparam int URGENT_MASK_W = `ARB_NUM_REQ;

  // ----------------------------------------
  // Register byte addresses
  // ----------------------------------------
  typedef enum logic [`ARB_APB_ADDR_W-1:0] {
    // Control word with the enable
    REG_CTRL        = 8'h00,
    // Urgent class mask
    REG_URGENT      = 8'h04,
    // Read-only grant cycle counter
    REG_GRANT_COUNT = 8'h08
  } regAddrE;

endpackage

//--- logic/arbTop.sv
// Arbiter top level splitting requests by class and wiring both grant paths
`timescale 1ns/1ps
`include "arbMacros.svh"

module arbTop (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       PSEL,
  input  logic                       PENABLE,
  input  logic                       PWRITE,
  input  logic [`ARB_APB_ADDR_W-1:0] PADDR,
  input  logic [`ARB_APB_DATA_W-1:0] PWDATA,
  output logic [`ARB_APB_DATA_W-1:0] PRDATA,
  output logic                       PREADY,
  output logic                       PSLVERR,
  input  logic [`ARB_NUM_REQ-1:0]    req,
  output logic [`ARB_NUM_REQ-1:0]    grant0,
  output logic [`ARB_NUM_REQ-1:0]    grant1,
  output arbGrantPkg::grantSrcE      grantSrc
);

  logic enable;
  logic [`ARB_NUM_REQ-1:0] urgentMask;
  logic [`ARB_NUM_REQ-1:0] urgentReq;
  logic [`ARB_NUM_REQ-1:0] normalReq;
  logic [`ARB_NUM_REQ-1:0] lowestPrio;
  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] urgentGrant;
  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] roundGrant;
  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] grant;
  logic [arbRegPkg::GRANT_COUNT_W-1:0] grantCount;

  // ----------------------------------------
  // Register block
  // ----------------------------------------
  arbApbRegs u_apbRegs (
    .clk       (clk),
    .rst       (rst),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PRDATA    (PRDATA),
    .PREADY    (PREADY),
    .PSLVERR   (PSLVERR),
    .enable    (enable),
    .urgentMask(urgentMask),
    .grantCount(grantCount)
  );

  // Request split by class
  assign urgentReq = req & urgentMask;
  assign normalReq = req & ~urgentMask;

  // ----------------------------------------
  // Grant paths
  // ----------------------------------------
  // Urgent class in fixed order
  encPriorityFixed #(
    .numRequesters(`ARB_NUM_REQ),
    .numResults(`ARB_NUM_GRANTS)
  ) u_encUrgent (
    .in (urgentReq),
    .out(urgentGrant)
  );

  // Normal class in rotating order
  encPriorityDynamic #(
    .numRequesters(`ARB_NUM_REQ),
    .numResults(`ARB_NUM_GRANTS)
  ) u_encRound (
    .clk       (clk),
    .rst       (rst),
    .in        (normalReq),
    .lowestPrio(lowestPrio),
    .out       (roundGrant)
  );

  grantCombiner u_combiner (
    .clk        (clk),
    .rst        (rst),
    .enable     (enable),
    .urgentGrant(urgentGrant),
    .roundGrant (roundGrant),
    .lowestPrio (lowestPrio),
    .grant      (grant),
    .grantSrc   (grantSrc),
    .grantCount (grantCount)
  );

  // Grant slots out as separate vectors
  assign grant0 = grant[0];
  assign grant1 = grant[1];

endmodule

//--- logic/encPriorityDynamic.sv
// Multi-result priority encoder with a runtime onehot lowest-priority position
`timescale 1ns/1ps

module encPriorityDynamic #(
  parameter int numRequesters = 8,
  parameter int numResults = 2
) (
  // Clock and reset carry no state in this combinational encoder
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic [numRequesters-1:0]                 in,
  input  logic [numRequesters-1:0]                 lowestPrio,
  output logic [numResults-1:0][numRequesters-1:0] out
);

  // Fixed encoder results needed
  // The last one comes for free when every requester gets a result
  localparam int internalResults =
      (numResults < numRequesters) ? numResults : numRequesters - 1;
  localparam int internalWidth = 2 * numRequesters;

  // ----------------------------------------
  // Priority split
  // ----------------------------------------
  // Mask covers lowestPrio and every bit below it
  logic [numRequesters-1:0] prioMask;
  logic [numRequesters-1:0] inHighPrio;
  logic [numRequesters-1:0] inLowPrio;
  logic [internalResults-1:0][internalWidth-1:0] wideOut;

  for (genvar b = 0; b < numRequesters; b++) begin : genMask
    assign prioMask[b] = |lowestPrio[numRequesters-1:b];
  end

  // Bits above the pointer come first
  assign inHighPrio = in & ~prioMask;
  // Bits at or below the pointer wait for the wrap
  assign inLowPrio = in & prioMask;

  // ----------------------------------------
  // Double-width fixed encoder
  // ----------------------------------------
  // High-priority requests in the low half win first
  encPriorityFixed #(
    .numRequesters(internalWidth),
    .numResults(internalResults)
  ) u_encWide (
    .in ({inLowPrio, inHighPrio}),
    .out(wideOut)
  );

  // Fold both halves back onto the requester index
  for (genvar r = 0; r < internalResults; r++) begin : genFold
    assign out[r] = wideOut[r][internalWidth-1:numRequesters] |
                    wideOut[r][numRequesters-1:0];
  end

  // ----------------------------------------
  // Leftover result
  // ----------------------------------------
  if (numResults == numRequesters) begin : genLast
    logic [numRequesters-1:0] leftover;

    // Whatever the earlier results did not take
    always_comb begin
      leftover = in;
      for (int r = 0; r < internalResults; r++) begin
        leftover = leftover & ~out[r];
      end
    end

    assign out[numResults-1] = leftover;
  end

endmodule

//--- logic/encPriorityFixed.sv
// Multi-result fixed priority encoder where index 0 has the highest priority
`timescale 1ns/1ps

module encPriorityFixed #(
  parameter int numRequesters = 8,
  parameter int numResults = 2
) (
  input  logic [numRequesters-1:0]                 in,
  output logic [numResults-1:0][numRequesters-1:0] out
);

  // ----------------------------------------
  // Successive lowest-bit picks
  // ----------------------------------------
  // Requests still waiting after the earlier results
  logic [numRequesters-1:0] remaining;

  always_comb begin
    remaining = in;
    for (int r = 0; r < numResults; r++) begin
      // Two's complement AND isolates the lowest set bit
      out[r] = remaining & (~remaining + 1'b1);
      // Drop it so the next result sees only the rest
      remaining = remaining & ~out[r];
    end
  end

  // Result r is zero once fewer than r+1 requests are present

endmodule

//--- logic/grantCombiner.sv
// Picks urgent or round-robin grants, registers them and keeps the rotating pointer
`timescale 1ns/1ps
`include "arbMacros.svh"

module grantCombiner (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         enable,
  input  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] urgentGrant,
  input  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] roundGrant,
  output logic [`ARB_NUM_REQ-1:0]                      lowestPrio,
  output logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] grant,
  output arbGrantPkg::grantSrcE                        grantSrc,
  output logic [arbRegPkg::GRANT_COUNT_W-1:0]          grantCount
);

  logic urgentAny;
  logic roundAny;
  logic [`ARB_NUM_REQ-1:0] lastGranted;
  logic [`ARB_NUM_GRANTS-1:0][`ARB_NUM_REQ-1:0] nextGrant;
  arbGrantPkg::grantSrcE nextSrc;

  // Slot 0 is set whenever any request of that class exists
  assign urgentAny = |urgentGrant[0];
  assign roundAny = |roundGrant[0];

  // ----------------------------------------
  // Pointer target
  // ----------------------------------------
  // Last nonzero slot is the latest in priority order
  always_comb begin
    lastGranted = roundGrant[0];
    for (int s = 1; s < `ARB_NUM_GRANTS; s++) begin
      if (|roundGrant[s]) begin
        lastGranted = roundGrant[s];
      end
    end
  end

  // ----------------------------------------
  // Source selection
  // ----------------------------------------
  always_comb begin
    nextGrant = '0;
    nextSrc = arbGrantPkg::GRANT_NONE;
    if (enable) begin
      // Urgent class preempts the round-robin class
      if (urgentAny) begin
        nextGrant = urgentGrant;
        nextSrc = arbGrantPkg::GRANT_URGENT;
      end else if (roundAny) begin
        nextGrant = roundGrant;
        nextSrc = arbGrantPkg::GRANT_ROUND;
      end
    end
  end

  // ----------------------------------------
  // Registered outputs
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= '0;
      grantSrc <= arbGrantPkg::GRANT_NONE;
      // Top bit lowest so index 0 starts with the highest priority
      lowestPrio <= {1'b1, {(`ARB_NUM_REQ-1){1'b0}}};
      grantCount <= '0;
    end else begin
      grant <= nextGrant;
      grantSrc <= nextSrc;
      // Only round-robin grants move the pointer
      if (nextSrc == arbGrantPkg::GRANT_ROUND) begin
        lowestPrio <= lastGranted;
      end
      if (nextSrc != arbGrantPkg::GRANT_NONE) begin
        grantCount <= grantCount + 1'b1;
      end
    end
  end

endmodule

//--- sim/arbChecker.sv
// Grant checker comparing registered DUT grants with the expected pattern values
`timescale 1ns/1ps
`include "arbMacros.svh"

module arbChecker (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    expValid,
  input  int                      expIdx,
  input  logic [`ARB_NUM_REQ-1:0] expGrant0,
  input  logic [`ARB_NUM_REQ-1:0] expGrant1,
  input  arbGrantPkg::grantSrcE   expSrc,
  input  logic [`ARB_NUM_REQ-1:0] grant0,
  input  logic [`ARB_NUM_REQ-1:0] grant1,
  input  arbGrantPkg::grantSrcE   grantSrc,
  output int                      errorCount,
  output int                      checkCount
);

  // Expectation for the request registered on the last rising edge
  logic pendValid;
  int pendIdx;
  logic [`ARB_NUM_REQ-1:0] pendGrant0;
  logic [`ARB_NUM_REQ-1:0] pendGrant1;
  arbGrantPkg::grantSrcE pendSrc;

  initial begin
    pendValid = 1'b0;
    errorCount = 0;
    checkCount = 0;
  end

  task automatic reportMismatch(input string field, input int got, input int exp);
    errorCount = errorCount + 1;
    $display("[ERROR] %0t: pattern %0d %s is %h, expected %h",
             $time, pendIdx, field, got, exp);
  endtask

  // ----------------------------------------
  // Capture on the edge that registers grants
  // ----------------------------------------
  always @(posedge clk) begin
    if (rst) begin
      pendValid <= 1'b0;
    end else begin
      pendValid <= expValid;
      pendIdx <= expIdx;
      pendGrant0 <= expGrant0;
      pendGrant1 <= expGrant1;
      pendSrc <= expSrc;
    end
  end

  // Grants are one cycle old and stable at the falling edge
  always @(negedge clk) begin
    if (pendValid) begin
      checkCount = checkCount + 1;
      if (grant0 !== pendGrant0) begin
        reportMismatch("grant0", grant0, pendGrant0);
      end
      if (grant1 !== pendGrant1) begin
        reportMismatch("grant1", grant1, pendGrant1);
      end
      if (grantSrc !== pendSrc) begin
        reportMismatch("grantSrc", grantSrc, pendSrc);
      end
    end
  end

endmodule

//--- sim/arbPatterns.txt
// Columns in hex: ctrl_mask_req_grant0_grant1_src, grants expected one cycle after req
// ctrl 0 keeps registers, 1 writes urgent mask, 2 writes enable from mask bit 0
// Disabled after reset
0_00_FF_00_00_0
0_00_21_00_00_0
// Enable with no urgent bits, all requests held
2_01_FF_01_02_2
0_00_FF_04_08_2
0_00_FF_10_20_2
0_00_FF_40_80_2
0_00_FF_01_02_2
// Urgent bits 5 and 6, pointer stays at 1
1_60_FF_20_40_1
0_00_60_20_40_1
0_00_21_20_00_1
0_00_9F_04_08_2
// Lone requests and wrap order
1_00_10_10_00_2
0_00_03_01_02_2
0_00_81_80_01_2
0_00_01_01_00_2
0_00_00_00_00_0
0_00_41_40_01_2
// Disabled again
2_00_FF_00_00_0

//--- sim/tbArbTop.sv
// Testbench top running the arbiter through the pattern file and the APB registers
`timescale 1ns/1ps
`include "arbMacros.svh"

module tbArbTop;

  localparam int patMax = 64;
  localparam int apbTimeout = 16;
  localparam int fillerCycles = 6;

  logic clk;
  logic rst;
  logic PSEL;
  logic PENABLE;
  logic PWRITE;
  logic [`ARB_APB_ADDR_W-1:0] PADDR;
  logic [`ARB_APB_DATA_W-1:0] PWDATA;
  logic [`ARB_APB_DATA_W-1:0] PRDATA;
  logic PREADY;
  logic PSLVERR;
  logic [`ARB_NUM_REQ-1:0] req;
  logic [`ARB_NUM_REQ-1:0] grant0;
  logic [`ARB_NUM_REQ-1:0] grant1;
  arbGrantPkg::grantSrcE grantSrc;

  // Expectation handed to the checker with each request
  logic expValid;
  int expIdx;
  logic [`ARB_NUM_REQ-1:0] expGrant0;
  logic [`ARB_NUM_REQ-1:0] expGrant1;
  arbGrantPkg::grantSrcE expSrc;

  // Pattern word is ctrl, mask, req, grant0, grant1, src
  logic [39:0] patterns [0:patMax-1];
  int numPatterns;
  int regErrors;
  int expGrantCycles;
  int checkErrors;
  int checkCount;
  integer seed;
  logic enableShadow;
  logic [`ARB_NUM_REQ-1:0] maskShadow;
  logic [`ARB_APB_DATA_W-1:0] rdData;
  logic slvErr;

  tbClock u_clock (
    .clk(clk)
  );

  arbTop u_arbTop (
    .clk     (clk),
    .rst     (rst),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR),
    .req     (req),
    .grant0  (grant0),
    .grant1  (grant1),
    .grantSrc(grantSrc)
  );

  arbChecker u_checker (
    .clk       (clk),
    .rst       (rst),
    .expValid  (expValid),
    .expIdx    (expIdx),
    .expGrant0 (expGrant0),
    .expGrant1 (expGrant1),
    .expSrc    (expSrc),
    .grant0    (grant0),
    .grant1    (grant1),
    .grantSrc  (grantSrc),
    .errorCount(checkErrors),
    .checkCount(checkCount)
  );

  // ----------------------------------------
  // APB transfers
  // ----------------------------------------
  // Setup and access phase that returns at a falling edge
  task automatic apbAccess(input logic write, input logic [`ARB_APB_ADDR_W-1:0] addr,
                           input logic [`ARB_APB_DATA_W-1:0] wdata,
                           output logic [`ARB_APB_DATA_W-1:0] rdata, output logic err);
    int waited;
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = write;
    PADDR = addr;
    PWDATA = wdata;
    @(negedge clk);
    PENABLE = 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (PREADY !== 1'b1 && waited < apbTimeout);
    if (PREADY !== 1'b1) begin
      $display("APB transfer to address %h timed out waiting for PREADY", addr);
      $display("TEST FAILED");
      $finish;
    end else begin
      // Requests are idle here, so read data holds across this edge
      rdata = PRDATA;
      err = PSLVERR;
      @(negedge clk);
      PSEL = 1'b0;
      PENABLE = 1'b0;
      PWRITE = 1'b0;
    end
  endtask

  task automatic regWrite(input logic [`ARB_APB_ADDR_W-1:0] addr,
                          input logic [`ARB_APB_DATA_W-1:0] data);
    logic [`ARB_APB_DATA_W-1:0] ignored;
    logic err;
    apbAccess(1'b1, addr, data, ignored, err);
    if (err !== 1'b0) begin
      regErrors++;
      $display("[ERROR] %0t: write to %h raised PSLVERR", $time, addr);
    end
  endtask

  task automatic regReadCheck(input logic [`ARB_APB_ADDR_W-1:0] addr,
                              input logic [`ARB_APB_DATA_W-1:0] exp);
    logic [`ARB_APB_DATA_W-1:0] got;
    logic err;
    apbAccess(1'b0, addr, '0, got, err);
    if (err !== 1'b0 || got !== exp) begin
      regErrors++;
      $display("[ERROR] %0t: read of %h gave %h err %b, expected %h",
               $time, addr, got, err, exp);
    end
  endtask

  // ----------------------------------------
  // Request stimulus
  // ----------------------------------------
  // Unchecked random requests
  task automatic driveFiller(input int cycles);
    logic [31:0] rnd;
    for (int c = 0; c < cycles; c++) begin
      rnd = $random(seed);
      req = rnd[`ARB_NUM_REQ-1:0];
      @(negedge clk);
    end
    req = '0;
  endtask

  task automatic applyPattern(input int idx);
    logic [39:0] pat;
    logic [`ARB_NUM_REQ-1:0] mask;
    pat = patterns[idx];
    mask = pat[35:28];
    if (pat[39:36] != 4'h0) begin
      req = '0;
      expValid = 1'b0;
      // Filler leaves pointer and counter alone while the arbiter is disabled
      if (!enableShadow) begin
        driveFiller(fillerCycles);
      end
      if (pat[39:36] == 4'h1) begin
        regWrite(arbRegPkg::REG_URGENT, mask);
        maskShadow = mask;
      end else begin
        regWrite(arbRegPkg::REG_CTRL, mask[0]);
        enableShadow = mask[0];
      end
    end
    req = pat[27:20];
    expValid = 1'b1;
    expIdx = idx;
    expGrant0 = pat[19:12];
    expGrant1 = pat[11:4];
    expSrc = arbGrantPkg::grantSrcE'(pat[1:0]);
    if (pat[3:0] != 4'h0) begin
      expGrantCycles++;
    end
    @(negedge clk);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    seed = 32'hf635_05f7;
    rst = 1'b1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    req = '0;
    expValid = 1'b0;
    expIdx = 0;
    expGrant0 = '0;
    expGrant1 = '0;
    expSrc = arbGrantPkg::GRANT_NONE;
    numPatterns = 0;
    regErrors = 0;
    expGrantCycles = 0;
    enableShadow = 1'b0;
    maskShadow = '0;

    $readmemh("sim/arbPatterns.txt", patterns);
    while (numPatterns < patMax && !$isunknown(patterns[numPatterns])) begin
      numPatterns++;
    end

    // Three cycles of reset
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (grant0 !== '0 || grant1 !== '0 || grantSrc !== arbGrantPkg::GRANT_NONE ||
        PSLVERR !== 1'b0) begin
      regErrors++;
      $display("[ERROR] %0t: outputs not idle after reset", $time);
    end
    if (numPatterns == 0) begin
      regErrors++;
      $display("No patterns could be read from sim/arbPatterns.txt");
    end

    for (int i = 0; i < numPatterns; i++) begin
      applyPattern(i);
    end
    req = '0;
    expValid = 1'b0;
    @(negedge clk);

    // Register readback
    regReadCheck(arbRegPkg::REG_CTRL, enableShadow);
    regWrite(arbRegPkg::REG_CTRL, 32'h0000_0001);
    enableShadow = 1'b1;
    regReadCheck(arbRegPkg::REG_CTRL, enableShadow);
    regWrite(arbRegPkg::REG_URGENT, 8'hA5);
    maskShadow = 8'hA5;
    regReadCheck(arbRegPkg::REG_URGENT, maskShadow);
    regReadCheck(arbRegPkg::REG_GRANT_COUNT, expGrantCycles);
    // Counter write is dropped quietly
    regWrite(arbRegPkg::REG_GRANT_COUNT, 32'h0000_1234);
    regReadCheck(arbRegPkg::REG_GRANT_COUNT, expGrantCycles);
    apbAccess(1'b0, 8'h0C, '0, rdData, slvErr);
    if (slvErr !== 1'b1) begin
      regErrors++;
      $display("[ERROR] %0t: unmapped address 0c gave PSLVERR %b", $time, slvErr);
    end
    if (checkCount != numPatterns) begin
      regErrors++;
      $display("Checker compared %0d patterns but %0d were applied", checkCount, numPatterns);
    end

    $display("Errors: %0d grant mismatches in %0d checks, %0d register errors",
             checkErrors, checkCount, regErrors);
    if (checkErrors == 0 && regErrors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/tbClock.sv
// Testbench clock source with a 10 ns period
`timescale 1ns/1ps

module tbClock #(
  // Half of the 10 ns period
  parameter int halfPeriod = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #halfPeriod clk = ~clk;

endmodule

//--- sources.f
+incdir+logic
logic/arbRegPkg.sv
logic/arbGrantPkg.sv
logic/encPriorityFixed.sv
logic/encPriorityDynamic.sv
logic/grantCombiner.sv
logic/arbApbRegs.sv
logic/arbTop.sv
sim/tbClock.sv
sim/arbChecker.sv
sim/tbArbTop.sv
